// ==== verilog.f ====
rv32i_types.sv
rob_pkg.sv
regfile_scoreboard.sv
reorder_buffer.sv
operand_resolver.sv
ooo_backend_top.sv
tb_ooo_backend.sv

// ==== tb_ooo_backend.sv ====
`default_nettype none

module tb_ooo_backend;

  localparam logic [1:0] act_idle  = 2'd0;
  localparam logic [1:0] act_issue = 2'd1;
  localparam logic [1:0] act_wb    = 2'd2;
  localparam logic [1:0] act_flush = 2'd3;

  localparam rv32i_types::opcode_t op_alu = 7'b0110011;
  localparam rv32i_types::opcode_t op_st  = rv32i_types::store_opcode;
  localparam rv32i_types::opcode_t op_br  = rv32i_types::br_opcode;

  // one clock of stimulus with the expected source operands
  typedef struct packed {
    logic [1:0]            act;
    rv32i_types::opcode_t  opcode;
    rv32i_types::reg_idx_t rd;
    rv32i_types::reg_idx_t rs1;
    rv32i_types::reg_idx_t rs2;
    rob_pkg::rob_tag_t     wb_tag;
    logic                  rdy1;
    rob_pkg::rob_tag_t     tag1;
    logic                  rdy2;
    rob_pkg::rob_tag_t     tag2;
  } row_t;

  // reference model of one buffer entry
  typedef struct packed {
    rob_pkg::rob_tag_t     tag;
    logic                  we;
    rv32i_types::reg_idx_t rd;
    logic                  done;
    rv32i_types::word_t    value;
  } model_entry_t;

  logic                clk;
  logic                rst;
  logic                flush;
  rob_pkg::issue_req_t issue;
  rob_pkg::wb_t        wb;
  logic                rob_full;
  rob_pkg::rob_tag_t   alloc_tag;
  rob_pkg::operand_t   rs1_op;
  rob_pkg::operand_t   rs2_op;
  rob_pkg::commit_t    commit;

  row_t               rows[$];
  logic               table_ready;
  logic [31:0]        lfsr_q;
  rv32i_types::word_t wb_word;

  rv32i_types::word_t m_regs [32];
  logic               m_pend [32];
  rob_pkg::rob_tag_t  m_owner [32];
  model_entry_t       m_rob[$];
  rob_pkg::rob_tag_t  m_tail;

  ooo_backend_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .issue     (issue),
    .wb        (wb),
    .rob_full  (rob_full),
    .alloc_tag (alloc_tag),
    .rs1_op    (rs1_op),
    .rs2_op    (rs2_op),
    .commit    (commit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit of the word
  task automatic draw_word(output rv32i_types::word_t w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic void add_row(logic [1:0] act, rv32i_types::opcode_t op,
                                  rv32i_types::reg_idx_t rd, rv32i_types::reg_idx_t rs1,
                                  rv32i_types::reg_idx_t rs2, rob_pkg::rob_tag_t wtag,
                                  logic rdy1, rob_pkg::rob_tag_t tag1,
                                  logic rdy2, rob_pkg::rob_tag_t tag2);
    row_t r;
    r = '{act, op, rd, rs1, rs2, wtag, rdy1, tag1, rdy2, tag2};
    rows.push_back(r);
  endfunction

  // act, opcode, rd, rs1, rs2, wb tag, rs1 ready, rs1 tag, rs2 ready, rs2 tag
  function automatic void build_table();
    // three writers with results back in reverse order
    add_row(act_issue, op_alu, 1, 0, 0, 0, 1, 0, 1, 0);
    add_row(act_issue, op_alu, 2, 1, 0, 0, 0, 0, 1, 0);
    add_row(act_issue, op_alu, 3, 1, 2, 0, 0, 0, 0, 1);
    add_row(act_wb,    op_alu, 0, 3, 2, 2, 0, 2, 0, 1);
    add_row(act_wb,    op_alu, 0, 3, 1, 1, 1, 0, 0, 0);
    add_row(act_wb,    op_alu, 0, 2, 3, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 1, 2, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 1, 3, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 2, 3, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 1, 2, 0, 1, 0, 1, 0);
    // x5 renamed twice followed by a store, a branch and a write to x0
    add_row(act_issue, op_alu, 5, 0, 0, 0, 1, 0, 1, 0);
    add_row(act_issue, op_alu, 5, 5, 0, 0, 0, 3, 1, 0);
    add_row(act_issue, op_st,  6, 5, 0, 0, 0, 4, 1, 0);
    add_row(act_issue, op_br,  7, 6, 0, 0, 1, 0, 1, 0);
    add_row(act_issue, op_alu, 0, 7, 0, 0, 1, 0, 1, 0);
    add_row(act_wb,    op_alu, 0, 5, 6, 3, 0, 4, 1, 0);
    add_row(act_idle,  op_alu, 0, 5, 0, 0, 0, 4, 1, 0);
    add_row(act_idle,  op_alu, 0, 5, 0, 0, 0, 4, 1, 0);
    add_row(act_wb,    op_alu, 0, 5, 0, 4, 0, 4, 1, 0);
    add_row(act_idle,  op_alu, 0, 5, 0, 0, 1, 0, 1, 0);
    add_row(act_wb,    op_alu, 0, 5, 6, 5, 1, 0, 1, 0);
    add_row(act_wb,    op_alu, 0, 0, 0, 6, 1, 0, 1, 0);
    add_row(act_wb,    op_alu, 0, 7, 0, 7, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 0, 0, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 0, 0, 0, 1, 0, 1, 0);
    // flush with three entries outstanding
    add_row(act_issue, op_alu, 1, 0, 0, 0, 1, 0, 1, 0);
    add_row(act_issue, op_alu, 2, 1, 0, 0, 0, 0, 1, 0);
    add_row(act_issue, op_alu, 3, 2, 1, 0, 0, 1, 0, 0);
    add_row(act_wb,    op_alu, 0, 1, 2, 1, 0, 0, 0, 1);
    add_row(act_flush, op_alu, 0, 1, 2, 0, 0, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 1, 2, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 3, 0, 0, 1, 0, 1, 0);
    add_row(act_issue, op_alu, 4, 0, 0, 0, 1, 0, 1, 0);
    add_row(act_wb,    op_alu, 0, 4, 0, 0, 0, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 4, 0, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 4, 0, 0, 1, 0, 1, 0);
    // fill all eight entries
    for (int i = 0; i < 8; i++) begin
      add_row(act_issue, op_alu, 5'(8 + i), 0, 0, 0, 1, 0, 1, 0);
    end
    add_row(act_wb,    op_alu, 0, 8, 15, 1, 0, 1, 0, 0);
    add_row(act_idle,  op_alu, 0, 8, 0, 0, 1, 0, 1, 0);
    add_row(act_idle,  op_alu, 0, 9, 0, 0, 0, 2, 1, 0);
    add_row(act_issue, op_alu, 16, 15, 8, 0, 0, 0, 1, 0);
  endfunction

  task automatic apply_row(input row_t r);
    rob_pkg::issue_req_t req;
    rob_pkg::wb_t        w;
    req = '{(r.act == act_issue), r.opcode, r.rd, r.rs1, r.rs2};
    w = '0;
    if (r.act == act_wb) begin
      draw_word(wb_word);
      w = '{1'b1, r.wb_tag, wb_word};
    end
    issue <= req;
    wb    <= w;
    flush <= (r.act == act_flush);
  endtask

  // operand as the model sees it before this clock edge
  function automatic rob_pkg::operand_t model_operand(rv32i_types::reg_idx_t r);
    rob_pkg::operand_t o;
    o = '{!m_pend[r], m_owner[r], m_regs[r]};
    for (int i = 0; i < m_rob.size(); i++) begin
      if (m_pend[r] && m_rob[i].tag == m_owner[r] && m_rob[i].done) begin
        o.ready = 1'b1;
        o.value = m_rob[i].value;
      end
    end
    return o;
  endfunction

  task automatic check_cycle(input row_t r, input int n);
    rob_pkg::operand_t e1;
    rob_pkg::operand_t e2;
    logic              head_done;
    logic              full_exp;
    e1 = model_operand(r.rs1);
    e2 = model_operand(r.rs2);
    head_done = (m_rob.size() > 0) ? m_rob[0].done : 1'b0;
    full_exp = (m_rob.size() == rob_pkg::rob_depth);
    check(32'(alloc_tag), 32'(m_tail), $sformatf("row %0d alloc_tag", n));
    check(32'(rob_full), 32'(full_exp), $sformatf("row %0d full", n));
    check(32'(rs1_op.ready), 32'(r.rdy1), $sformatf("row %0d rs1 ready", n));
    check(32'(rs1_op.ready), 32'(e1.ready), $sformatf("row %0d rs1 ready vs model", n));
    if (r.rdy1) begin
      check(rs1_op.value, e1.value, $sformatf("row %0d rs1 value", n));
    end else begin
      check(32'(rs1_op.tag), 32'(r.tag1), $sformatf("row %0d rs1 tag", n));
    end
    check(32'(rs2_op.ready), 32'(r.rdy2), $sformatf("row %0d rs2 ready", n));
    check(32'(rs2_op.ready), 32'(e2.ready), $sformatf("row %0d rs2 ready vs model", n));
    if (r.rdy2) begin
      check(rs2_op.value, e2.value, $sformatf("row %0d rs2 value", n));
    end else begin
      check(32'(rs2_op.tag), 32'(r.tag2), $sformatf("row %0d rs2 tag", n));
    end
    check(32'(commit.valid), 32'(head_done), $sformatf("row %0d commit valid", n));
    if (head_done) begin
      check(32'(commit.tag), 32'(m_rob[0].tag), $sformatf("row %0d commit tag", n));
      check(32'(commit.we), 32'(m_rob[0].we), $sformatf("row %0d commit we", n));
      check(32'(commit.rd), 32'(m_rob[0].rd), $sformatf("row %0d commit rd", n));
      check(commit.value, m_rob[0].value, $sformatf("row %0d commit value", n));
    end
  endtask

  // state change at the clock edge that ends the row
  task automatic model_edge(input row_t r);
    model_entry_t e;
    logic         writes;
    writes = (r.rd != 5'd0) && (r.opcode != op_st) && (r.opcode != op_br);
    if (r.act == act_flush) begin
      m_rob.delete();
      m_tail = '0;
      for (int i = 0; i < 32; i++) begin
        m_pend[i] = 1'b0;
      end
    end else begin
      if (m_rob.size() > 0 && m_rob[0].done) begin
        e = m_rob.pop_front();
        if (e.we && e.rd != 5'd0) begin
          m_regs[e.rd] = e.value;
        end
        if (e.we && m_pend[e.rd] && m_owner[e.rd] == e.tag) begin
          m_pend[e.rd] = 1'b0;
        end
      end
      for (int i = 0; i < m_rob.size(); i++) begin
        if (r.act == act_wb && m_rob[i].tag == r.wb_tag) begin
          m_rob[i].done  = 1'b1;
          m_rob[i].value = wb_word;
        end
      end
      if (r.act == act_issue) begin
        if (writes) begin
          m_pend[r.rd]  = 1'b1;
          m_owner[r.rd] = m_tail;
        end
        m_rob.push_back('{m_tail, writes, r.rd, 1'b0, 32'h0});
        m_tail = m_tail + 1'b1;
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    flush       = 1'b0;
    issue       = '0;
    wb          = '0;
    table_ready = 1'b0;
    lfsr_q      = 32'he4f0;
    wb_word     = '0;
    m_tail      = '0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i]  = '0;
      m_pend[i]  = 1'b0;
      m_owner[i] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
      @(negedge clk);
      check_cycle(rows[i], i);
      model_edge(rows[i]);
      @(posedge clk);
    end
    $display("** PASS **");
    $finish;
  end

  // four clocks per row is far beyond the one the table needs
  initial begin
    wait (table_ready);
    #(rows.size() * 20 * 4);
    $display("timeout: the stimulus table did not finish in time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== ooo_backend_top.sv ====
`default_nettype none

module ooo_backend_top (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                flush,
  input  wire rob_pkg::issue_req_t issue,
  input  wire rob_pkg::wb_t        wb,
  output logic                     rob_full,
  output rob_pkg::rob_tag_t        alloc_tag,
  output rob_pkg::operand_t        rs1_op,
  output rob_pkg::operand_t        rs2_op,
  output rob_pkg::commit_t         commit
);

  rob_pkg::operand_t  rs1_raw;
  rob_pkg::operand_t  rs2_raw;
  logic               lookup_done1;
  logic               lookup_done2;
  rv32i_types::word_t lookup_val1;
  rv32i_types::word_t lookup_val2;

  regfile_scoreboard u_regfile (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .issue     (issue),
    .alloc_tag (alloc_tag),
    .commit    (commit),
    .rs1_raw   (rs1_raw),
    .rs2_raw   (rs2_raw)
  );

  // lookups go by the producer tag from the scoreboard
  reorder_buffer u_rob (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .issue        (issue),
    .wb           (wb),
    .lookup_tag1  (rs1_raw.tag),
    .lookup_tag2  (rs2_raw.tag),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .lookup_done1 (lookup_done1),
    .lookup_done2 (lookup_done2),
    .lookup_val1  (lookup_val1),
    .lookup_val2  (lookup_val2),
    .commit       (commit)
  );

  operand_resolver u_res1 (
    .raw      (rs1_raw),
    .rob_done (lookup_done1),
    .rob_val  (lookup_val1),
    .op       (rs1_op)
  );

  operand_resolver u_res2 (
    .raw      (rs2_raw),
    .rob_done (lookup_done2),
    .rob_val  (lookup_val2),
    .op       (rs2_op)
  );

endmodule

`default_nettype wire

// ==== operand_resolver.sv ====
`default_nettype none

module operand_resolver (
  input  wire rob_pkg::operand_t  raw,
  input  wire logic               rob_done,
  input  wire rv32i_types::word_t rob_val,
  output rob_pkg::operand_t       op
);

  // producer finished but not yet retired
  logic forward;

  assign forward = !raw.ready && rob_done;

  // tag always follows the register file answer
  // so a still-pending source keeps pointing at its producer
  always_comb begin
    op = raw;
    if (forward) begin
      op.ready = 1'b1;
      op.value = rob_val;
    end
  end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`default_nettype none

module reorder_buffer (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                flush,
  input  wire rob_pkg::issue_req_t issue,
  input  wire rob_pkg::wb_t        wb,
  input  wire rob_pkg::rob_tag_t   lookup_tag1,
  input  wire rob_pkg::rob_tag_t   lookup_tag2,
  output rob_pkg::rob_tag_t        alloc_tag,
  output logic                     rob_full,
  output logic                     lookup_done1,
  output logic                     lookup_done2,
  output rv32i_types::word_t       lookup_val1,
  output rv32i_types::word_t       lookup_val2,
  output rob_pkg::commit_t         commit
);

  // per-entry payload
  typedef struct packed {
    logic                  we;
    rv32i_types::reg_idx_t rd;
    rv32i_types::word_t    value;
  } rob_entry_t;

  rob_entry_t                      ent_q [rob_pkg::rob_depth];
  logic [rob_pkg::rob_depth-1:0]   busy_q;
  logic [rob_pkg::rob_depth-1:0]   done_q;

  rob_pkg::rob_tag_t               head_q;
  rob_pkg::rob_tag_t               tail_q;
  logic [rob_pkg::rob_tag_w:0]     count_q;

  logic do_alloc;
  logic do_retire;

  assign alloc_tag = tail_q;
  assign rob_full  = (count_q == rob_pkg::rob_depth);

  // full is a software contract, the gate only protects the buffer state
  assign do_alloc  = issue.valid && !rob_full;
  assign do_retire = commit.valid;

  // head entry retires as soon as its result is in
  always_comb begin
    commit.valid = busy_q[head_q] && done_q[head_q];
    commit.we    = ent_q[head_q].we;
    commit.rd    = ent_q[head_q].rd;
    commit.value = ent_q[head_q].value;
    commit.tag   = head_q;
  end

  // operand lookups for the two sources
  always_comb begin
    lookup_done1 = busy_q[lookup_tag1] && done_q[lookup_tag1];
    lookup_val1  = ent_q[lookup_tag1].value;
    lookup_done2 = busy_q[lookup_tag2] && done_q[lookup_tag2];
    lookup_val2  = ent_q[lookup_tag2].value;
  end

  // control state, flush beats everything else
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      busy_q  <= '0;
      done_q  <= '0;
    end else begin
      if (do_retire) begin
        busy_q[head_q] <= 1'b0;
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (wb.valid) begin
        done_q[wb.tag] <= 1'b1;
      end
      if (do_alloc) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end

      // alloc and retire together leave the count unchanged
      case ({do_alloc, do_retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (do_alloc) begin
      ent_q[tail_q].we <= rv32i_types::writes_rd(issue.opcode, issue.rd);
      ent_q[tail_q].rd <= issue.rd;
    end
    if (wb.valid) begin
      ent_q[wb.tag].value <= wb.value;
    end
  end

  // issue side must respect the full level
  a_no_issue_when_full : assert property (
    @(posedge clk) disable iff (rst)
    issue.valid |-> !rob_full
  ) else $error("issue while reorder buffer full");

  // results only for live entries
  a_wb_to_busy : assert property (
    @(posedge clk) disable iff (rst)
    wb.valid && !flush |-> busy_q[wb.tag]
  ) else $error("writeback to free entry %0d", wb.tag);

  // each entry is written back exactly once
  a_wb_once : assert property (
    @(posedge clk) disable iff (rst)
    wb.valid && !flush |-> !done_q[wb.tag]
  ) else $error("second writeback to entry %0d", wb.tag);

endmodule

`default_nettype wire

// ==== regfile_scoreboard.sv ====
`default_nettype none

module regfile_scoreboard (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                flush,
  input  wire rob_pkg::issue_req_t issue,
  input  wire rob_pkg::rob_tag_t   alloc_tag,
  input  wire rob_pkg::commit_t    commit,
  output rob_pkg::operand_t        rs1_raw,
  output rob_pkg::operand_t        rs2_raw
);

  // architectural state
  rv32i_types::word_t regs_q [32];

  // scoreboard, producer tag per register
  rob_pkg::rob_tag_t  owner_q [32];
  logic [31:0]        pending_q;

  logic issue_writes;
  logic commit_writes;
  logic owner_match;

  assign issue_writes  = issue.valid && rv32i_types::writes_rd(issue.opcode, issue.rd);
  assign commit_writes = commit.valid && commit.we && (commit.rd != 5'd0);

  // retiring tag still owns the register, nothing younger has renamed it
  assign owner_match = pending_q[commit.rd] && (owner_q[commit.rd] == commit.tag);

  // register values
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (!flush && commit_writes) begin
      regs_q[commit.rd] <= commit.value;
    end
  end

  // pending flags
  // issue comes after the commit clear so a rename in the same cycle wins
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
    end else if (flush) begin
      pending_q <= '0;
    end else begin
      if (commit_writes && owner_match) begin
        pending_q[commit.rd] <= 1'b0;
      end
      if (issue_writes) begin
        pending_q[issue.rd] <= 1'b1;
      end
    end
  end

  // producer tags, only meaningful while pending
  always_ff @(posedge clk) begin
    if (issue_writes) begin
      owner_q[issue.rd] <= alloc_tag;
    end
  end

  // source reads from current state
  always_comb begin
    rs1_raw.ready = !pending_q[issue.rs1];
    rs1_raw.tag   = owner_q[issue.rs1];
    rs1_raw.value = regs_q[issue.rs1];

    rs2_raw.ready = !pending_q[issue.rs2];
    rs2_raw.tag   = owner_q[issue.rs2];
    rs2_raw.value = regs_q[issue.rs2];
  end

  // x0 is hardwired, it never waits on a producer
  a_x0_never_pending : assert property (
    @(posedge clk) disable iff (rst)
    !pending_q[0]
  ) else $error("register zero marked pending");

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  // reorder buffer geometry
  localparam int rob_depth = 8;
  localparam int rob_tag_w = 3;

  typedef logic [rob_tag_w-1:0] rob_tag_t;

  // one in-order issue slot
  typedef struct packed {
    logic                 valid;
    rv32i_types::opcode_t opcode;
    rv32i_types::reg_idx_t rd;
    rv32i_types::reg_idx_t rs1;
    rv32i_types::reg_idx_t rs2;
  } issue_req_t;

  // retirement of the head entry into the register file
  typedef struct packed {
    logic                  valid;
    logic                  we;
    rv32i_types::reg_idx_t rd;
    rv32i_types::word_t    value;
    rob_tag_t              tag;
  } commit_t;

  // result returned by an execution unit
  typedef struct packed {
    logic               valid;
    rob_tag_t           tag;
    rv32i_types::word_t value;
  } wb_t;

  // source operand, either a value or the tag of its producer
  typedef struct packed {
    logic               ready;
    rob_tag_t           tag;
    rv32i_types::word_t value;
  } operand_t;

endpackage

`default_nettype wire

// ==== rv32i_types.sv ====
`default_nettype none

package rv32i_types;

  // data path and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // opcodes that never write a destination register
  localparam opcode_t store_opcode = 7'b0100011;
  localparam opcode_t br_opcode    = 7'b1100011;

  // true when an instruction produces a value for rd
  function automatic logic writes_rd(opcode_t opcode, reg_idx_t rd);
    logic no_dest;
    no_dest = (opcode == store_opcode) || (opcode == br_opcode);
    return (rd != 5'd0) && !no_dest;
  endfunction

endpackage

`default_nettype wire
